/* source/msx_bus_pkg.sv */
// MSX bus glue package with widths, port numbers, SDRAM windows and pipeline item types
package msx_bus_pkg;

	// ------------------------------------------------------------------------
	// Plain vector types
	// ------------------------------------------------------------------------
	typedef logic [15:0] cpu_addr_t;		// Z80 address bus
	typedef logic [7:0]  cpu_data_t;		// Z80 data bus
	typedef logic [22:0] sdram_addr_t;		// SDRAM byte address, 8MB
	typedef logic [1:0]  slot_num_t;		// Slot or subslot number
	typedef logic [7:0]  segment_t;			// Mapper segment, 16KB units
	typedef logic [9:0]  win_t;				// SDRAM address bits 22:13

	// ------------------------------------------------------------------------
	// I/O ports and special addresses
	// ------------------------------------------------------------------------
	localparam cpu_data_t port_slot_select = 8'hA8;		// PPI port A, primary slot
	localparam cpu_data_t port_mapper_base = 8'hFC;		// FCh-FFh, one per page
	localparam cpu_addr_t addr_subslot_reg = 16'hFFFF;	// Expanded slot register

	// SDRAM 8KB windows of the ROM images
	localparam win_t win_main_rom    = 10'h010;		// 32KB, 4 banks
	localparam win_t win_basic_n     = 10'h018;		// 16KB
	localparam win_t win_music       = 10'h01A;		// 16KB
	localparam win_t win_logo_ext    = 10'h01C;		// 32KB
	localparam win_t win_sub_rom     = 10'h020;		// 16KB
	localparam win_t win_kanji_basic = 10'h014;		// 32KB, pages 1-3 folded
	localparam win_t win_nextor      = 10'h000;		// 64KB

	// Page 0 gets segment 3 ... page 3 gets segment 0, as the BIOS expects
	localparam segment_t [3:0] mapper_reset_segments = {8'h00, 8'h01, 8'h02, 8'h03};

	localparam cpu_data_t open_bus_data = 8'hFF;		// Nothing drives the bus

	// ------------------------------------------------------------------------
	// Cycle and command kinds
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		mem_rd,
		mem_wr,
		io_rd,
		io_wr,
		resolved_rd			// Read already answered by stage one
	} bus_kind_t;

	typedef enum logic [1:0] {
		cmd_none,
		cmd_sdram_rd,
		cmd_sdram_wr,
		cmd_local_rd		// Data comes with the command
	} cmd_kind_t;

	// ------------------------------------------------------------------------
	// Pipeline items
	// ------------------------------------------------------------------------
	typedef struct packed {
		bus_kind_t kind;
		cpu_addr_t addr;
		cpu_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		bus_kind_t kind;
		cpu_addr_t addr;
		cpu_data_t wdata;
		slot_num_t slot;		// Primary slot of the page
		slot_num_t subslot;		// Zero for non expanded slots
		cpu_data_t rdata;		// Only for resolved_rd
	} slot_item_t;

	typedef struct packed {
		cmd_kind_t   kind;
		sdram_addr_t addr;
		cpu_data_t   data;		// Write data or local read data
	} mem_cmd_t;

endpackage

/* source/slot_select.sv */
// Stage one: primary and secondary slot registers, tags every bus cycle with its slot
`timescale 1ns/10ps

module slot_select import msx_bus_pkg::*; (
	input  logic       clk42m,
	input  logic       ff_reset0_n,
	input  bus_req_t   in,
	input  logic       in_valid,
	output logic       in_ready,
	output slot_item_t out,
	output logic       out_valid,
	input  logic       out_ready
);
	slot_num_t [3:0] ff_primary;		// One slot per 16KB page
	slot_num_t [3:0] ff_sub0;			// Subslots of slot 0
	slot_num_t [3:0] ff_sub3;			// Subslots of slot 3
	slot_item_t      ff_item;
	logic            ff_valid;

	logic            w_accept;
	logic [1:0]      w_page;
	slot_num_t       w_page_slot;
	slot_num_t       w_top_slot;
	slot_num_t [3:0] w_top_sub;
	logic            w_is_mem;
	logic            w_slot_io;
	logic            w_sub_access;
	slot_item_t      w_item;

	// ------------------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------------------
	assign in_ready    = !ff_valid || out_ready;		// Empty or draining
	assign w_accept    = in_valid && in_ready;
	assign w_page      = in.addr[15:14];
	assign w_page_slot = ff_primary[w_page];
	assign w_top_slot  = ff_primary[3];					// FFFFh lives in page 3
	assign w_top_sub   = (w_top_slot == 2'd0) ? ff_sub0 : ff_sub3;

	assign w_is_mem  = (in.kind == mem_rd) || (in.kind == mem_wr);
	assign w_slot_io = ((in.kind == io_rd) || (in.kind == io_wr)) &&
		(in.addr[7:0] == port_slot_select);

	// Subslot register only exists in the expanded slots
	assign w_sub_access = w_is_mem && (in.addr == addr_subslot_reg) &&
		((w_top_slot == 2'd0) || (w_top_slot == 2'd3));

	always_comb begin
		w_item.kind    = in.kind;
		w_item.addr    = in.addr;
		w_item.wdata   = in.wdata;
		w_item.slot    = 2'd0;
		w_item.subslot = 2'd0;
		w_item.rdata   = open_bus_data;
		if (w_slot_io && (in.kind == io_rd)) begin
			w_item.kind  = resolved_rd;
			w_item.rdata = ff_primary;		// A8h reads back as written
		end
		else if (w_sub_access) begin
			if (in.kind == mem_rd) begin
				w_item.kind  = resolved_rd;
				w_item.rdata = ~w_top_sub;	// Read back inverted
			end
			else begin
				// Register write, no RAM behind it; slot 1 maps nowhere
				w_item.slot = 2'd1;
			end
		end
		else if (w_is_mem) begin
			w_item.slot = w_page_slot;
			if (w_page_slot == 2'd0) begin
				w_item.subslot = ff_sub0[w_page];
			end
			else if (w_page_slot == 2'd3) begin
				w_item.subslot = ff_sub3[w_page];
			end
		end
	end

	// ------------------------------------------------------------------------
	// Slot registers, written when the item enters this stage
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_primary <= '0;
			ff_sub0    <= '0;
			ff_sub3    <= '0;
		end
		else if (w_accept) begin
			if (w_slot_io && (in.kind == io_wr)) begin
				ff_primary <= in.wdata;
			end
			if (w_sub_access && (in.kind == mem_wr)) begin
				if (w_top_slot == 2'd0) begin
					ff_sub0 <= in.wdata;
				end
				else begin
					ff_sub3 <= in.wdata;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_valid <= 1'b0;
		end
		else if (in_ready) begin
			ff_valid <= in_valid;				// Refill or go empty
		end
	end

	always_ff @(posedge clk42m) begin
		if (w_accept) begin
			ff_item <= w_item;
		end
	end

	assign out       = ff_item;
	assign out_valid = ff_valid;

endmodule

/* source/sdram_map.sv */
// Stage two: memory mapper registers, turns tagged bus cycles into SDRAM commands
`timescale 1ns/10ps

module sdram_map import msx_bus_pkg::*; (
	input  logic       clk42m,
	input  logic       ff_reset0_n,
	input  slot_item_t in,
	input  logic       in_valid,
	output logic       in_ready,
	output mem_cmd_t   out,
	output logic       out_valid,
	input  logic       out_ready
);
	segment_t [3:0] ff_seg;			// Segment per page, FCh..FFh
	mem_cmd_t       ff_cmd;
	logic           ff_valid;

	logic           w_accept;
	logic [1:0]     w_page;
	logic           w_mapper_port;
	win_t           w_upper;		// SDRAM address bits 22:13
	logic           w_rd_ok;
	logic           w_wr_ok;
	mem_cmd_t       w_cmd;

	assign in_ready = !ff_valid || out_ready;
	assign w_accept = in_valid && in_ready;
	assign w_page   = in.addr[15:14];

	// FCh-FFh, lower two bits pick the page
	assign w_mapper_port = (in.addr[7:2] == port_mapper_base[7:2]);

	// ------------------------------------------------------------------------
	// Window map per slot and subslot
	// ------------------------------------------------------------------------
	always_comb begin
		w_upper = '0;
		w_rd_ok = 1'b0;
		w_wr_ok = 1'b0;
		case ({in.slot, in.subslot})
			4'b11_00: begin							// Mapper RAM, 4MB upper half
				w_upper = {1'b1, ff_seg[w_page], in.addr[13]};
				w_rd_ok = 1'b1;
				w_wr_ok = 1'b1;
			end
			4'b00_00: begin							// Main ROM
				w_upper = win_main_rom | {8'd0, in.addr[14:13]};
				w_rd_ok = !in.addr[15];
			end
			4'b00_01: begin							// BASIC'N
				w_upper = win_basic_n | {9'd0, in.addr[13]};
				w_rd_ok = (w_page == 2'd1);
			end
			4'b00_10: begin							// MSX-MUSIC
				w_upper = win_music | {9'd0, in.addr[13]};
				w_rd_ok = (w_page == 2'd1);
			end
			4'b00_11: begin							// Logo and extended BASIC
				w_upper = win_logo_ext | {8'd0, in.addr[14:13]};
				w_rd_ok = (w_page == 2'd1) || (w_page == 2'd2);
			end
			4'b11_01: begin
				if (w_page == 2'd0) begin
					w_upper = win_sub_rom | {9'd0, in.addr[13]};
				end
				else begin
					// Kanji BASIC, page 3 aliases page 2
					w_upper = win_kanji_basic | {8'd0, in.addr[15], in.addr[13]};
				end
				w_rd_ok = 1'b1;
			end
			4'b11_10: begin							// Nextor
				w_upper = win_nextor | {7'd0, in.addr[15:13]};
				w_rd_ok = (w_page == 2'd1) || (w_page == 2'd2);
			end
			default: begin
				// Slots 1, 2 and 3-3 are empty
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Command per item kind
	// ------------------------------------------------------------------------
	always_comb begin
		w_cmd.kind = cmd_none;
		w_cmd.addr = '0;
		w_cmd.data = 8'h00;
		case (in.kind)
			mem_rd: begin
				if (w_rd_ok) begin
					w_cmd.kind = cmd_sdram_rd;
					w_cmd.addr = {w_upper, in.addr[12:0]};
				end
				else begin
					w_cmd.kind = cmd_local_rd;
					w_cmd.data = open_bus_data;
				end
			end
			mem_wr: begin
				if (w_wr_ok) begin					// Only RAM takes writes
					w_cmd.kind = cmd_sdram_wr;
					w_cmd.addr = {w_upper, in.addr[12:0]};
					w_cmd.data = in.wdata;
				end
			end
			io_rd: begin
				w_cmd.kind = cmd_local_rd;
				w_cmd.data = w_mapper_port ? ff_seg[in.addr[1:0]] : open_bus_data;
			end
			resolved_rd: begin
				w_cmd.kind = cmd_local_rd;
				w_cmd.data = in.rdata;
			end
			default: begin
				// io_wr has no command
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Mapper registers and output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_seg   <= mapper_reset_segments;
			ff_valid <= 1'b0;
		end
		else begin
			if (w_accept && (in.kind == io_wr) && w_mapper_port) begin
				ff_seg[in.addr[1:0]] <= in.wdata;
			end
			if (in_ready) begin
				ff_valid <= in_valid;
			end
		end
	end

	always_ff @(posedge clk42m) begin
		if (w_accept) begin
			ff_cmd <= w_cmd;
		end
	end

	assign out       = ff_cmd;
	assign out_valid = ff_valid;

endmodule

/* source/msx_bus_top.sv */
// MSX bus glue top level, slot decode followed by SDRAM address mapping
`timescale 1ns/10ps

module msx_bus_top import msx_bus_pkg::*; (
	input  logic     clk42m,
	input  logic     ff_reset0_n,
	input  bus_req_t req,			// One CPU bus cycle
	input  logic     req_valid,
	output logic     req_ready,
	output mem_cmd_t cmd,			// Towards the SDRAM controller
	output logic     cmd_valid,
	input  logic     cmd_ready
);
	slot_item_t w_item;
	logic       w_item_valid;
	logic       w_item_ready;

	// ------------------------------------------------------------------------
	// Stage one, slot registers
	// ------------------------------------------------------------------------
	slot_select u_slot_select (
		.clk42m      ( clk42m       ),
		.ff_reset0_n ( ff_reset0_n  ),
		.in          ( req          ),
		.in_valid    ( req_valid    ),
		.in_ready    ( req_ready    ),
		.out         ( w_item       ),
		.out_valid   ( w_item_valid ),
		.out_ready   ( w_item_ready )
	);

	// ------------------------------------------------------------------------
	// Stage two, mapper and window map
	// ------------------------------------------------------------------------
	sdram_map u_sdram_map (
		.clk42m      ( clk42m       ),
		.ff_reset0_n ( ff_reset0_n  ),
		.in          ( w_item       ),
		.in_valid    ( w_item_valid ),
		.in_ready    ( w_item_ready ),
		.out         ( cmd          ),
		.out_valid   ( cmd_valid    ),
		.out_ready   ( cmd_ready    )
	);

endmodule

/* bench/tb_model.svh */
// Reference model of the slot, mapper and SDRAM window rules, with the random generator
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] m_primary;		// Port A8h
logic [7:0] m_sub0;			// Expanded slot 0
logic [7:0] m_sub3;			// Expanded slot 3
logic [7:0] m_seg [4];		// Mapper pages 0-3

function automatic logic [31:0] next_random(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;	// Plain LCG
endfunction

function automatic void clear_model_state();
	m_primary = 8'h00;
	m_sub0    = 8'h00;
	m_sub3    = 8'h00;
	for (int i = 0; i < 4; i++) begin
		m_seg[i] = 8'(3 - i);		// Page 0 starts on segment 3
	end
endfunction

// One accepted request in, the command it must produce out
function automatic mem_cmd_t predict_cmd(input bus_req_t r);
	mem_cmd_t   c;
	logic [7:0] lo;
	logic [1:0] page;
	logic [1:0] top;
	logic [1:0] slot;
	logic [1:0] sub;
	logic [9:0] up;
	logic       rd_ok;
	logic       wr_ok;
	c.kind = cmd_none;
	c.addr = '0;
	c.data = 8'h00;
	lo     = r.addr[7:0];
	page   = r.addr[15:14];
	top    = m_primary[7:6];
	up     = '0;
	rd_ok  = 1'b0;
	wr_ok  = 1'b0;
	if (r.kind == io_wr) begin
		if (lo == 8'hA8) m_primary = r.wdata;
		if (lo >= 8'hFC) m_seg[lo[1:0]] = r.wdata;
	end
	else if (r.kind == io_rd) begin
		c.kind = cmd_local_rd;
		c.data = (lo == 8'hA8) ? m_primary : (lo >= 8'hFC) ? m_seg[lo[1:0]] : 8'hFF;
	end
	else if (r.addr == 16'hFFFF && (top == 2'd0 || top == 2'd3)) begin
		if (r.kind == mem_wr && top == 2'd0) m_sub0 = r.wdata;
		else if (r.kind == mem_wr) m_sub3 = r.wdata;
		else begin
			c.kind = cmd_local_rd;
			c.data = ~((top == 2'd0) ? m_sub0 : m_sub3);	// Reads back inverted
		end
	end
	else begin
		slot = m_primary[page*2 +: 2];
		sub  = (slot == 2'd0) ? m_sub0[page*2 +: 2] :
			(slot == 2'd3) ? m_sub3[page*2 +: 2] : 2'd0;
		case ({slot, sub})
			4'b1100: begin up = {1'b1, m_seg[page], r.addr[13]}; rd_ok = 1; wr_ok = 1; end
			4'b0000: begin up = win_main_rom + {8'd0, r.addr[14:13]}; rd_ok = page < 2; end
			4'b0001: begin up = win_basic_n + {9'd0, r.addr[13]}; rd_ok = page == 1; end
			4'b0010: begin up = win_music + {9'd0, r.addr[13]}; rd_ok = page == 1; end
			4'b0011: begin up = win_logo_ext + {8'd0, r.addr[14:13]}; rd_ok = page[1] ^ page[0]; end
			4'b1101: begin
				up = (page == 0) ? win_sub_rom + {9'd0, r.addr[13]} :
					win_kanji_basic + {8'd0, r.addr[15], r.addr[13]};
				rd_ok = 1;
			end
			4'b1110: begin up = win_nextor + {7'd0, r.addr[15:13]}; rd_ok = page[1] ^ page[0]; end
			default: up = '0;		// Empty slot
		endcase
		if (r.kind == mem_rd && rd_ok) begin
			c.kind = cmd_sdram_rd;
			c.addr = {up, r.addr[12:0]};
		end
		else if (r.kind == mem_rd) begin
			c.kind = cmd_local_rd;
			c.data = 8'hFF;
		end
		else if (wr_ok) begin
			c.kind = cmd_sdram_wr;
			c.addr = {up, r.addr[12:0]};
			c.data = r.wdata;
		end
	end
	return c;
endfunction

`endif

/* bench/tb_msx_bus.sv */
// Testbench of the MSX bus glue, model driven checks of slots, mapper and handshake
`timescale 1ns/10ps

module tb_msx_bus import msx_bus_pkg::*; ();
	logic     clk42m;
	logic     ff_reset0_n;
	bus_req_t req;
	logic     req_valid;
	logic     req_ready;
	mem_cmd_t cmd;
	logic     cmd_valid;
	logic     cmd_ready;

	mem_cmd_t    exp_q[$];		// Expected commands, acceptance order
	mem_cmd_t    cur_exp;		// Head for the handshake at the next edge
	logic        cur_has;
	logic [31:0] rng;
	logic [31:0] stall_rng;
	logic        stall_mode;
	logic        stall_now;		// Stall mode as it stood at the edge
	logic        lat_mode;
	logic        b2b_mode;
	int          cyc;

	`include "tb_model.svh"

	msx_bus_top dut_i (
		.clk42m      ( clk42m      ),
		.ff_reset0_n ( ff_reset0_n ),
		.req         ( req         ),
		.req_valid   ( req_valid   ),
		.req_ready   ( req_ready   ),
		.cmd         ( cmd         ),
		.cmd_valid   ( cmd_valid   ),
		.cmd_ready   ( cmd_ready   )
	);

	initial begin
		clk42m = 1'b0;
		forever #4 clk42m = ~clk42m;		// 8 ns
	end

	task automatic fail_now(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic give_up(input string msg);
		$display("%0t ns: %s", $time, msg);
		$display("Something failed");
		$fatal(1);
	endtask

	// ------------------------------------------------------------------------
	// Bookkeeping at the falling edge, where all handshake signals are settled
	// ------------------------------------------------------------------------
	always @(posedge clk42m) cyc <= cyc + 1;

	always @(negedge clk42m) begin
		if (ff_reset0_n) begin
			if (cmd_valid && cmd_ready) begin
				cur_has = (exp_q.size() != 0);
				if (cur_has) cur_exp = exp_q.pop_front();
			end
			if (req_valid && req_ready) exp_q.push_back(predict_cmd(req));
		end
	end

	always @(posedge clk42m) begin
		stall_now = stall_mode;
		#1;
		if (stall_now) begin
			stall_rng = next_random(stall_rng);
			cmd_ready = (stall_rng[21:20] != 2'b00);	// Ready three times in four
		end
		else cmd_ready = 1'b1;
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	a_cmd_match: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		(cmd_valid && cmd_ready) |-> (cur_has && cmd == cur_exp))
		else fail_now("command differs from the model");
	a_stall_hold: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		$past(cmd_valid && !cmd_ready) |-> (cmd_valid && cmd == $past(cmd)))
		else fail_now("command changed while stalled");
	a_reset_idle: assert property (@(posedge clk42m)
		(cyc > 1 && !$past(ff_reset0_n)) |-> (!cmd_valid && req_ready))
		else fail_now("handshake not idle after reset");
	a_lat_early: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		(lat_mode && $past(req_valid && req_ready)) |-> !cmd_valid)
		else fail_now("cmd_valid one clock after acceptance");
	a_lat_two: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		(lat_mode && $past(req_valid && req_ready, 2)) |-> cmd_valid)
		else fail_now("cmd_valid missing two clocks after acceptance");
	a_b2b: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		(b2b_mode && req_valid) |-> req_ready)
		else fail_now("request refused while streaming");

	// ------------------------------------------------------------------------
	// Stimulus, always entered 1 ns after a rising edge
	// ------------------------------------------------------------------------
	task automatic send_req(input bus_kind_t kind, input cpu_addr_t addr, input cpu_data_t wd);
		int n;
		n         = 0;
		req.kind  = kind;
		req.addr  = addr;
		req.wdata = wd;
		req_valid = 1'b1;
		@(negedge clk42m);
		while (!req_ready) begin
			n++;
			if (n > 100) give_up("req_ready stuck low");
			@(negedge clk42m);
		end
		@(posedge clk42m);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge clk42m);
		#2;
		while (exp_q.size() != 0 || cmd_valid) begin
			n++;
			if (n > 200) give_up("pipeline did not drain");
			@(posedge clk42m);
			#2;
		end
		@(posedge clk42m);
		#1;
	endtask

	task automatic send_random();
		bus_kind_t k;
		cpu_addr_t a;
		rng = next_random(rng);
		k   = bus_kind_t'(rng[31:30]);		// Memory or I/O, read or write
		a   = rng[15:0];
		if (k == io_rd || k == io_wr) begin
			if (rng[29:27] == 0) a[7:0] = 8'hA8;
			else if (rng[29:27] < 4) a[7:0] = {6'h3F, rng[1:0]};
		end
		else if (rng[26:24] == 0) a = 16'hFFFF;
		rng = next_random(rng);
		send_req(k, a, rng[23:16]);
		if (rng[3:0] == 0) begin		// Idle gap
			@(posedge clk42m);
			#1;
		end
	endtask

	initial begin
		ff_reset0_n = 1'b0;
		req         = '0;
		req_valid   = 1'b0;
		cmd_ready   = 1'b1;
		stall_mode  = 1'b0;
		lat_mode    = 1'b0;
		b2b_mode    = 1'b0;
		cur_has     = 1'b0;
		cur_exp     = '0;
		cyc         = 0;
		rng         = 32'h40183321;
		stall_rng   = ~rng;
		clear_model_state();
		repeat (10) @(posedge clk42m);
		#1;
		ff_reset0_n = 1'b1;

		// Main ROM and FFFFh straight out of reset
		for (int i = 0; i < 8; i++) send_req(mem_rd, 16'(i * 16'h1000 + 16'h0123), 8'h00);
		send_req(mem_rd, 16'hFFFF, 8'h00);
		wait_idle();

		// Every slot and subslot on every page
		for (int s = 0; s < 4; s++) begin
			send_req(io_wr, 16'h00A8, {4{2'(s)}});
			send_req(io_rd, 16'h00A8, 8'h00);
			for (int n = 0; n < 4; n++) begin
				send_req(mem_wr, 16'hFFFF, {4{2'(n)}});
				send_req(mem_rd, 16'hFFFF, 8'h00);
				for (int p = 0; p < 8; p++) begin
					send_req(mem_rd, 16'(p * 16'h2000 + 16'h0A5C), 8'h00);
				end
				send_req(mem_wr, 16'h8123, 8'h5A);
			end
		end
		wait_idle();

		// Mapper in slot 3-0, reset segments first
		send_req(io_wr, 16'h00A8, 8'hFF);
		send_req(mem_wr, 16'hFFFF, 8'h00);
		for (int r = 0; r < 3; r++) begin
			for (int p = 0; p < 4; p++) send_req(io_rd, 16'(16'h00FC + p), 8'h00);
			for (int p = 0; p < 8; p++) begin
				send_req(mem_wr, 16'(p * 16'h2000 + 16'h0011), 8'(p));
				send_req(mem_rd, 16'(p * 16'h2000 + 16'h1FF0), 8'h00);
			end
			for (int p = 0; p < 4; p++) begin
				rng = next_random(rng);
				send_req(io_wr, 16'(16'h00FC + p), rng[15:8]);
			end
		end
		wait_idle();

		// Random mix under back-pressure
		stall_mode = 1'b1;
		for (int i = 0; i < 300; i++) send_random();
		wait_idle();
		stall_mode = 1'b0;
		wait_idle();

		// Latency of a lone item, then a stream
		lat_mode = 1'b1;
		for (int i = 0; i < 4; i++) begin
			send_random();
			wait_idle();
		end
		lat_mode = 1'b0;
		b2b_mode = 1'b1;
		for (int i = 0; i < 16; i++) send_req(mem_rd, 16'(i * 16'h0400), 8'h00);
		b2b_mode = 1'b0;
		wait_idle();

		$display("Everything OK");
		$finish;
	end

endmodule

/* sim.f */
+incdir+bench
source/msx_bus_pkg.sv
source/slot_select.sv
source/sdram_map.sv
source/msx_bus_top.sv
bench/tb_msx_bus.sv

/* Makefile */
# Verilator build and run of the MSX bus glue testbench

VERILATOR ?= verilator
TOP       ?= tb_msx_bus
LINT_TOP  ?= msx_bus_top
FLIST     ?= sim.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only source/msx_bus_pkg.sv source/slot_select.sv \
		source/sdram_map.sv source/msx_bus_top.sv --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
